/* project.f */
+incdir+source
source/hub_frame_pkg.sv
source/hub_client_pkg.sv
source/rx_framer.sv
source/echo_client.sv
source/tx_merge.sv
source/client_hub_top.sv
verif/client_hub_asserts.sv
verif/client_hub_tb.sv

/* source/client_hub_top.sv */
// client hub top, framer feeding a bank of echo clients
// replies are merged back onto one strobed byte stream
`timescale 1ns/1ps
`include "hub_settings.svh"

module client_hub_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  hub_frame_pkg::byte_t     rx_data,
	input  logic                     rx_dv,
	output hub_frame_pkg::byte_t     tx_data,
	output logic                     tx_strobe,
	output logic                     tx_done,
	output hub_frame_pkg::drop_cnt_t drop_count
);

	import hub_frame_pkg::*;
	import hub_client_pkg::*;

	// client bus, broadcast from the framer
	byte_t       idata;
	len_t        len_c;
	logic        raw_l;  // long frame strobe, watched from outside
	logic        raw_s;
	client_sel_t client_sel;

	// one reply byte per client
	byte_t [`HUB_N_CLIENTS-1:0] odata_all;

	rx_framer rx_framer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_data    (rx_data),
		.rx_dv      (rx_dv),
		.idata      (idata),
		.len_c      (len_c),
		.raw_l      (raw_l),
		.raw_s      (raw_s),
		.client_sel (client_sel),
		.drop_count (drop_count)
	);

	// identical clients, each sees raw_s but keeps only its own frames
	for (genvar i = 0; i < `HUB_N_CLIENTS; i++) begin : g_client
		echo_client echo_client_inst (
			.clk   (clk),
			.rst_n (rst_n),
			.idata (idata),
			.len_c (len_c),
			.raw_s (raw_s),
			.sel   (client_sel[i]),
			.odata (odata_all[i])
		);
	end

	tx_merge tx_merge_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.raw_s      (raw_s),
		.client_sel (client_sel),
		.odata_all  (odata_all),
		.tx_data    (tx_data),
		.tx_strobe  (tx_strobe),
		.tx_done    (tx_done)
	);

endmodule

/* source/echo_client.sv */
// echo client, returns its payload after a fixed latency
// last two bytes are replaced by the packet sequence number and an xor checksum
`timescale 1ns/1ps
`include "hub_settings.svh"

module echo_client (
	input  logic                 clk,
	input  logic                 rst_n,
	input  hub_frame_pkg::byte_t idata,
	input  hub_frame_pkg::len_t  len_c,
	input  logic                 raw_s,
	input  logic                 sel,
	output hub_frame_pkg::byte_t odata
);

	import hub_frame_pkg::*;
	import hub_client_pkg::*;

	logic  take;                  // payload byte meant for this client
	byte_t push_byte;             // byte entering the pipeline
	seq_t  seq;
	csum_t csum;
	byte_t pipe [`HUB_N_LAT];     // fixed latency delay line

	assign take = raw_s & sel;  // broadcast bus, select checked here only

	// trailer substitution by remaining count
	always_comb begin
		if (!take)
			push_byte = '0;  // keeps idle output quiet
		else if (len_c == len_t'(2))
			push_byte = byte_t'(seq);
		else if (len_c == len_t'(1))
			push_byte = byte_t'(csum);
		else
			push_byte = idata;  // plain echo
	end

	// sequence and checksum state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seq  <= '0;
			csum <= '0;
		end else if (take) begin
			if (len_c == len_t'(1)) begin
				// last byte, packet done
				seq  <= seq + 1'b1;
				csum <= '0;  // ready for next packet
			end else if (len_c > len_t'(2)) begin
				csum <= csum ^ csum_t'(idata);  // only echoed bytes count
			end
		end
	end

	// delay line shifts every cycle, so latency is exactly HUB_N_LAT
	always_ff @(posedge clk) begin
		pipe[0] <= push_byte;
		for (int i = 1; i < `HUB_N_LAT; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	assign odata = pipe[`HUB_N_LAT-1];

endmodule

/* source/hub_client_pkg.sv */
// client side types of the client hub
// sequence number, checksum and the one-hot client select
`include "hub_settings.svh"

package hub_client_pkg;

	// per client packet count, sent as the next to last reply byte
	typedef logic [7:0] seq_t;

	// running xor of the echoed bytes, sent as the last reply byte
	typedef logic [7:0] csum_t;

	// one bit per client, at most one bit set
	typedef logic [`HUB_N_CLIENTS-1:0] client_sel_t;

endpackage

/* source/hub_frame_pkg.sv */
// frame side types of the client hub
// byte, length and counter widths plus the framer state encoding
package hub_frame_pkg;

	// one byte on the line or on the client bus
	typedef logic [7:0] byte_t;

	// payload length from the header, also the remaining count len_c
	typedef logic [10:0] len_t;

	// port byte exactly as received, before range check
	typedef logic [7:0] port_t;

	// dropped frame counter, wraps
	typedef logic [15:0] drop_cnt_t;

	// framer states
	typedef enum logic [2:0] {
		idle,      // waiting for rx_dv
		preamble,  // 0x55 run, ends at sfd
		port,      // port byte
		len_hi,    // length high byte
		len_lo,    // length low byte, limits checked here
		payload,   // streaming to the addressed client
		tail,      // raw_l hold after payload
		drop       // bad frame, wait for rx_dv to fall
	} framer_state_t;

endpackage

/* source/hub_settings.svh */
// client hub build settings
// sizes, latency, frame limits and framing byte values shared by RTL and testbench
`ifndef HUB_SETTINGS_SVH
`define HUB_SETTINGS_SVH

// number of echo clients behind the hub, one per port byte value
`define HUB_N_CLIENTS 4

// client pipeline depth, idata to odata
`define HUB_N_LAT 3

// payload length limits, in bytes, including the two trailer bytes
`define HUB_MAX_LEN 1500
`define HUB_MIN_LEN 3

// raw_l stays up this many cycles after raw_s falls
`define HUB_TAIL 4

// framing bytes, as on an ethernet line
`define HUB_PREAMBLE_BYTE 8'h55
`define HUB_SFD_BYTE 8'hd5

`endif

/* source/rx_framer.sv */
// rx framer, parses preamble, sfd and the 3 byte header from the rx byte stream
// presents payload on the client bus and counts dropped frames
`timescale 1ns/1ps
`include "hub_settings.svh"

module rx_framer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  hub_frame_pkg::byte_t        rx_data,
	input  logic                        rx_dv,
	output hub_frame_pkg::byte_t        idata,
	output hub_frame_pkg::len_t         len_c,
	output logic                        raw_l,
	output logic                        raw_s,
	output hub_client_pkg::client_sel_t client_sel,
	output hub_frame_pkg::drop_cnt_t    drop_count
);

	import hub_frame_pkg::*;
	import hub_client_pkg::*;

	framer_state_t state;
	byte_t         len_hi_byte;  // header length, high byte
	logic [15:0]   hdr_len;      // full header length, wide enough for any byte pair
	len_t          len_cnt;      // payload bytes left, then reused as tail timer
	logic          drop_now;     // current byte decides a drop
	port_t         port_byte;

	assign port_byte = rx_data;
	assign hdr_len = {len_hi_byte, rx_data};

	// drop decision for the byte on rx_data in the current state
	always_comb begin
		drop_now = 1'b0;
		if (rx_dv) begin
			case (state)
				idle:     drop_now = rx_data != `HUB_PREAMBLE_BYTE;  // frame must open with 0x55
				preamble: drop_now = rx_data != `HUB_PREAMBLE_BYTE && rx_data != `HUB_SFD_BYTE;
				port:     drop_now = port_byte >= `HUB_N_CLIENTS;
				len_lo:   drop_now = hdr_len < `HUB_MIN_LEN || hdr_len > `HUB_MAX_LEN;
				default:  drop_now = 1'b0;
			endcase
		end
	end

	// line byte is registered every cycle, the strobes say when it counts
	always_ff @(posedge clk) begin
		idata <= rx_data;
		if (state == len_hi)
			len_hi_byte <= rx_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= idle;
			raw_s      <= 1'b0;
			len_c      <= '0;
			len_cnt    <= '0;
			client_sel <= '0;
			drop_count <= '0;
		end else begin
			raw_s <= 1'b0;  // strobe only on payload bytes
			len_c <= '0;
			if (drop_now) begin
				state      <= drop;
				client_sel <= '0;  // addressed client never sees raw_s
				drop_count <= drop_count + 1'b1;
			end else begin
				case (state)
					idle: begin
						if (rx_dv)
							state <= preamble;  // first 0x55
					end
					preamble: begin
						if (!rx_dv)
							state <= idle;  // runt, nothing to count
						else if (rx_data == `HUB_SFD_BYTE)
							state <= port;
					end
					port: begin
						if (!rx_dv) begin
							state <= idle;
						end else begin
							// port already range checked, one-hot from the low bits
							client_sel <= client_sel_t'(1) << port_byte;
							state      <= len_hi;
						end
					end
					len_hi: begin
						if (!rx_dv) begin
							state      <= idle;
							client_sel <= '0;
						end else begin
							state <= len_lo;
						end
					end
					len_lo: begin
						if (!rx_dv) begin
							state      <= idle;
							client_sel <= '0;
						end else begin
							len_cnt <= len_t'(hdr_len);  // limits passed, fits in 11 bits
							state   <= payload;
						end
					end
					payload: begin
						if (rx_dv) begin
							raw_s <= 1'b1;
							len_c <= len_cnt;  // length on first byte, 1 on last
							if (len_cnt == len_t'(1)) begin
								len_cnt <= len_t'(`HUB_TAIL);  // reload as tail timer
								state   <= tail;
							end else begin
								len_cnt <= len_cnt - 1'b1;
							end
						end
					end
					tail: begin
						if (len_cnt == '0) begin
							state      <= idle;
							client_sel <= '0;  // held until the merge has used it
						end else begin
							len_cnt <= len_cnt - 1'b1;
						end
					end
					drop: begin
						if (!rx_dv)
							state <= idle;
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// long strobe, up from first preamble byte on idata through the tail
	// dropped frames take it down again
	assign raw_l = state != idle && state != drop;

endmodule

/* source/tx_merge.sv */
// tx merge, delays the payload strobe and client select to match client latency
// picks the addressed client's byte and flags the end of each reply
`timescale 1ns/1ps
`include "hub_settings.svh"

module tx_merge (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        raw_s,
	input  hub_client_pkg::client_sel_t                 client_sel,
	input  hub_frame_pkg::byte_t [`HUB_N_CLIENTS-1:0]   odata_all,
	output hub_frame_pkg::byte_t                        tx_data,
	output logic                                        tx_strobe,
	output logic                                        tx_done
);

	import hub_frame_pkg::*;
	import hub_client_pkg::*;

	logic [`HUB_N_LAT-1:0] strobe_pipe;         // raw_s delay
	client_sel_t           sel_pipe [`HUB_N_LAT];  // select travels with the strobe
	logic                  strobe_q;            // tx_strobe one cycle back

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			strobe_pipe <= '0;
			strobe_q    <= 1'b0;
			for (int i = 0; i < `HUB_N_LAT; i++) begin
				sel_pipe[i] <= '0;
			end
		end else begin
			strobe_pipe <= {strobe_pipe[`HUB_N_LAT-2:0], raw_s};
			strobe_q    <= tx_strobe;
			sel_pipe[0] <= client_sel;
			for (int i = 1; i < `HUB_N_LAT; i++) begin
				sel_pipe[i] <= sel_pipe[i-1];
			end
		end
	end

	// lines up with the client delay lines
	assign tx_strobe = strobe_pipe[`HUB_N_LAT-1];

	// one cycle pulse after the last strobe of a reply
	assign tx_done = strobe_q & ~tx_strobe;

	// one-hot and-or mux, zero when no client is selected
	always_comb begin
		tx_data = '0;
		for (int i = 0; i < `HUB_N_CLIENTS; i++) begin
			if (sel_pipe[`HUB_N_LAT-1][i])
				tx_data = tx_data | odata_all[i];
		end
	end

endmodule

/* verif/client_hub_asserts.sv */
// client hub timing checks, bound into the top level
// a line side frame model drives latency, echo, end of reply, raw_l tail and drop checks
`timescale 1ns/1ps
`include "hub_settings.svh"

module client_hub_asserts (
	input logic                     clk,
	input logic                     rst_n,
	input hub_frame_pkg::byte_t     rx_data,
	input logic                     rx_dv,
	input logic                     raw_l,
	input logic                     raw_s,
	input hub_frame_pkg::byte_t     tx_data,
	input logic                     tx_strobe,
	input logic                     tx_done,
	input hub_frame_pkg::drop_cnt_t drop_count
);

	import hub_frame_pkg::*;

	int fail_count = 0;  // failed assertions so far

	// line side model of the frame being received
	logic        sfd_seen;  // sfd passed in this rx_dv burst
	logic        bad;       // frame judged bad, held to the end of rx_dv
	logic [1:0]  hdr_idx;   // header bytes taken, 3 once the header is done
	byte_t       hi_byte;   // length high byte from the header
	logic [15:0] hdr_len;
	logic [15:0] left;      // payload bytes still to come
	logic        pay_now;   // rx_data is a payload byte of a good frame
	logic        echo_now;  // payload byte that comes back unchanged
	logic        last_now;  // last payload byte

	assign hdr_len  = {hi_byte, rx_data};
	assign pay_now  = rx_dv && !bad && hdr_idx == 2'd3 && left != '0;
	assign echo_now = pay_now && left > 16'd2;  // last two go out as trailer
	assign last_now = pay_now && left == 16'd1;

	always_ff @(posedge clk) begin
		if (!rst_n || !rx_dv) begin
			sfd_seen <= 1'b0;
			bad      <= 1'b0;
			hdr_idx  <= '0;
			left     <= '0;
		end else if (!bad) begin
			if (!sfd_seen) begin
				if (rx_data == `HUB_SFD_BYTE)
					sfd_seen <= 1'b1;
				else if (rx_data != `HUB_PREAMBLE_BYTE)
					bad <= 1'b1;  // broken preamble
			end else if (hdr_idx == 2'd0) begin
				bad     <= rx_data >= `HUB_N_CLIENTS;  // no such client
				hdr_idx <= 2'd1;
			end else if (hdr_idx == 2'd1) begin
				hi_byte <= rx_data;
				hdr_idx <= 2'd2;
			end else if (hdr_idx == 2'd2) begin
				bad     <= hdr_len < `HUB_MIN_LEN || hdr_len > `HUB_MAX_LEN;
				left    <= hdr_len;
				hdr_idx <= 2'd3;
			end else if (left != '0) begin
				left <= left - 1'b1;
			end
		end
	end

	// payload byte reaches the client bus one cycle after the line, dropped frames never
	a_raw_s_from_line: assert property (@(posedge clk) disable iff (!rst_n)
		raw_s == $past(pay_now))
		else begin
			$error("raw_s does not follow the payload bytes on the line");
			fail_count++;
		end

	// tx_strobe is the line payload 4 cycles late
	a_strobe_latency: assert property (@(posedge clk) disable iff (!rst_n)
		tx_strobe == $past(pay_now, `HUB_N_LAT + 1))
		else begin
			$error("tx_strobe out of step with payload");
			fail_count++;
		end

	// echoed bytes only, trailer slots come from the header length
	a_echo_data: assert property (@(posedge clk) disable iff (!rst_n)
		$past(echo_now, `HUB_N_LAT + 1) |->
			tx_data == $past(rx_data, `HUB_N_LAT + 1))
		else begin
			$error("echoed tx_data differs from rx_data");
			fail_count++;
		end

	a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		$past(last_now, `HUB_N_LAT + 1) |=> tx_done)  // end of every reply
		else begin
			$error("no tx_done after last tx_strobe");
			fail_count++;
		end

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
		tx_done |-> $past(last_now, `HUB_N_LAT + 2))  // one cycle, only there
		else begin
			$error("stray tx_done");
			fail_count++;
		end

	// long strobe holds for the tail after the last payload byte, then drops
	a_raw_l_tail: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(raw_s) |-> raw_l [*`HUB_TAIL] ##1 !raw_l)
		else begin
			$error("raw_l tail has the wrong length");
			fail_count++;
		end

	// quiet outputs during and just after reset
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !tx_strobe && !tx_done)
		else begin
			$error("tx strobes active in reset");
			fail_count++;
		end

	// one step per bad frame, right after the deciding byte
	a_drop_step: assert property (@(posedge clk) disable iff (!rst_n)
		drop_count == $past(drop_count) + $rose(bad))
		else begin
			$error("drop_count does not match the dropped frames");
			fail_count++;
		end

endmodule

bind client_hub_top client_hub_asserts client_hub_asserts_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.rx_data    (rx_data),
	.rx_dv      (rx_dv),
	.raw_l      (raw_l),
	.raw_s      (raw_s),
	.tx_data    (tx_data),
	.tx_strobe  (tx_strobe),
	.tx_done    (tx_done),
	.drop_count (drop_count)
);

/* verif/client_hub_tb.sv */
// client hub testbench, lcg driven frames with a byte level reply model
// checks echo, trailer, per port sequence and drops, timing via bound assertions
`timescale 1ns/1ps
`include "hub_settings.svh"

module client_hub_tb;

	import hub_frame_pkg::*;

	localparam int CLK_NS = 40;
	localparam int GAP = `HUB_TAIL + 2;  // idle cycles between frames
	localparam int MAX_RAND_LEN = 48;
	localparam int N_FRAMES = 6 + 12 + 4;  // sequence, echo, drop tests
	localparam int SLOT = 8 + 3 + MAX_RAND_LEN + GAP + 64;  // one frame plus drain bound
	localparam longint WATCHDOG_NS = 2 * longint'(N_FRAMES * SLOT + `HUB_MAX_LEN) * CLK_NS;

	logic      clk;
	logic      rst_n;
	byte_t     rx_data;
	logic      rx_dv;
	byte_t     tx_data;
	logic      tx_strobe;
	logic      tx_done;
	drop_cnt_t drop_count;

	logic [31:0] seed = 32'hf94a_9180;
	byte_t exp_q [$];                      // reply bytes still to come
	byte_t want_byte;
	byte_t seq_model [`HUB_N_CLIENTS];     // next sequence byte per port
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errs_before;
	int bind_fails;
	drop_cnt_t drops_before;
	port_t f_port;
	int f_len;

	client_hub_top client_hub_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// compare every reply byte as it leaves, outputs settled at the falling edge
	always @(negedge clk) begin
		if (rst_n && tx_strobe) begin
			assert (exp_q.size() > 0) else begin
				$display("tx_strobe at %0t while no reply byte was expected", $time);
				errors++;
			end
			if (exp_q.size() > 0) begin
				want_byte = exp_q.pop_front();
				assert (tx_data == want_byte) else begin
					$display("error at %0t: tx_data is %02h, expected %02h", $time, tx_data, want_byte);
					errors++;
				end
			end
		end
	end

	task automatic drive_byte(input byte_t b);
		rx_data = b;
		rx_dv   = 1'b1;
		@(negedge clk);
	endtask

	// full frame on the line, reply bytes queued for the monitor first
	task automatic send_frame(input port_t port, input int len, input bit bad_pre);
		byte_t pl [$];
		byte_t csum;
		bit good;
		good = !bad_pre && port < `HUB_N_CLIENTS && len >= `HUB_MIN_LEN && len <= `HUB_MAX_LEN;
		csum = '0;
		for (int i = 0; i < (good ? len : 4); i++) begin  // dropped frames carry a stub
			seed = lcg_next(seed);
			pl.push_back(seed[23:16]);
		end
		if (good) begin
			for (int i = 0; i < len - 2; i++) begin
				exp_q.push_back(pl[i]);
				csum ^= pl[i];
			end
			exp_q.push_back(seq_model[port]);
			exp_q.push_back(csum);
			seq_model[port]++;
		end
		for (int i = 0; i < 7; i++)
			drive_byte((bad_pre && i == 3) ? 8'h5a : `HUB_PREAMBLE_BYTE);
		drive_byte(`HUB_SFD_BYTE);
		drive_byte(port);
		drive_byte(byte_t'(len >> 8));  // length, high byte first
		drive_byte(byte_t'(len));
		foreach (pl[i])
			drive_byte(pl[i]);
		rx_dv = 1'b0;
		repeat (GAP) @(negedge clk);
	endtask

	task automatic rand_frame(output port_t port, output int len);
		seed = lcg_next(seed);
		port = port_t'(seed[25:24]);
		len  = `HUB_MIN_LEN + int'(seed[19:8]) % (MAX_RAND_LEN - `HUB_MIN_LEN + 1);
	endtask

	task automatic wait_replies();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 64) begin
			@(negedge clk);
			n++;
		end
		assert (exp_q.size() == 0) else begin
			$display("%0d reply bytes never came out on tx_data", exp_q.size());
			errors++;
		end
		exp_q.delete();
	endtask

	task automatic end_test(input string name, input int fails);
		tests_run++;
		if (fails == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d failed checks", name, fails);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("Verification failed");
		$finish;
	end

	initial begin
		rst_n   = 1'b0;
		rx_data = '0;
		rx_dv   = 1'b0;
		foreach (seq_model[i])
			seq_model[i] = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		// port 2 gets sequence bytes 0, 1, 2 between frames to other ports
		errs_before = errors;
		send_frame(2, 10, 0);
		send_frame(0, 7, 0);
		send_frame(2, 5, 0);
		send_frame(1, 12, 0);
		send_frame(2, 9, 0);
		send_frame(3, 4, 0);
		wait_replies();
		end_test("per-client sequence", errors - errs_before);

		errs_before = errors;
		send_frame(1, `HUB_MIN_LEN, 0);
		send_frame(3, `HUB_MAX_LEN, 0);
		for (int i = 0; i < 10; i++) begin
			rand_frame(f_port, f_len);
			send_frame(f_port, f_len, 0);
		end
		wait_replies();
		end_test("echo and trailer", errors - errs_before);

		// bad preamble, port 4, length 2, length 1501
		errs_before = errors;
		for (int k = 0; k < 4; k++) begin
			drops_before = drop_count;
			case (k)
				0: send_frame(0, 8, 1);
				1: send_frame(4, 8, 0);
				2: send_frame(1, 2, 0);
				default: send_frame(2, `HUB_MAX_LEN + 1, 0);
			endcase
			assert (drop_count == drops_before + 1'b1) else begin
				$display("error at %0t: drop_count is %0d, expected %0d",
					$time, drop_count, drops_before + 1'b1);
				errors++;
			end
		end
		wait_replies();
		end_test("drops", errors - errs_before);

		bind_fails = client_hub_top_inst.client_hub_asserts_inst.fail_count;
		end_test("latency, end pulse and reset state", bind_fails);

		$display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, bind_fails);
		if (tests_failed == 0 && errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
